// ==== verilog/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// ======================================================================
// datapath sizes
// ======================================================================

// data word width
`define XLEN 32

// architectural registers, x0 included
`define NUM_REGS 32

// register index width
`define REG_ADDR_W 5

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

// ==== verilog/riscv_pkg.sv ====
`include "core_params.svh"

package riscv_pkg;

  // ======================================================================
  // encodings
  // ======================================================================

  // major opcodes handled by the core
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_e;

  // alu function select
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // ======================================================================
  // instruction word views
  // ======================================================================

  // register layout, also covers the i-type
  // funct7 and rs2 together form imm[11:0] there
  typedef struct packed {
    logic [6:0]             funct7;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [2:0]             funct3;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } r_fmt_t;

  // upper immediate layout for lui
  typedef struct packed {
    logic [19:0]            imm_hi;
    logic [`REG_ADDR_W-1:0] rd;
    logic [6:0]             opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    u_fmt_t u_fmt;
  } inst_u;

  // ======================================================================
  // pipeline registers
  // ======================================================================

  // decode to execute
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       op1_data;
    logic [`XLEN-1:0]       op2_data;
    logic [`XLEN-1:0]       imm;
    alu_op_e                alu_op;
    logic                   use_imm;
    logic                   is_lui;
    logic                   reg_write;
  } id_ex_t;

  // execute to writeback
  typedef struct packed {
    logic                   valid;
    logic                   reg_write;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       result;
  } ex_wb_t;

endpackage

// ==== verilog/alu.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module alu (
  input  riscv_pkg::alu_op_e op_i,
  input  logic [`XLEN-1:0]   a_i,
  input  logic [`XLEN-1:0]   b_i,
  output logic [`XLEN-1:0]   result_o
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // rv32 shifts only look at the low five bits
  assign shamt       = b_i[4:0];
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      riscv_pkg::ALU_ADD:  result_o = a_i + b_i;
      riscv_pkg::ALU_SUB:  result_o = a_i - b_i;
      riscv_pkg::ALU_SLL:  result_o = a_i << shamt;
      riscv_pkg::ALU_SLT:  result_o = {{(`XLEN-1){1'b0}}, lt_signed};
      riscv_pkg::ALU_SLTU: result_o = {{(`XLEN-1){1'b0}}, lt_unsigned};
      riscv_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      riscv_pkg::ALU_SRL:  result_o = a_i >> shamt;
      // arithmetic shift keeps the sign
      riscv_pkg::ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      riscv_pkg::ALU_OR:   result_o = a_i | b_i;
      riscv_pkg::ALU_AND:  result_o = a_i & b_i;
      default:             result_o = '0;
    endcase
  end

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   we_i,
  input  logic [`REG_ADDR_W-1:0] waddr_i,
  input  logic [`XLEN-1:0]       wdata_i,
  input  logic [`REG_ADDR_W-1:0] raddr1_i,
  input  logic [`REG_ADDR_W-1:0] raddr2_i,
  output logic [`XLEN-1:0]       rdata1_o,
  output logic [`XLEN-1:0]       rdata2_o
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // x0 is never written
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // same-cycle write shows through to the reader
  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
    logic [`XLEN-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (we_i && (addr == waddr_i)) begin
      data = wdata_i;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    rdata1_o = read_port(raddr1_i);
    rdata2_o = read_port(raddr2_i);
  end

  // writeback data must be resolved when it lands
  a_wdata_known: assert property (@(posedge clk) disable iff (!rst_n_i)
    we_i |-> !$isunknown(wdata_i));

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module decode_stage (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   inst_valid_i,
  input  logic [`XLEN-1:0]       inst_i,
  output logic [`REG_ADDR_W-1:0] rs1_o,
  output logic [`REG_ADDR_W-1:0] rs2_o,
  input  logic [`XLEN-1:0]       rdata1_i,
  input  logic [`XLEN-1:0]       rdata2_i,
  output riscv_pkg::id_ex_t      id_ex_o
);

  riscv_pkg::inst_u   inst_q;
  logic               valid_q;
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;
  logic [`XLEN-1:0]   imm_i;
  logic [`XLEN-1:0]   imm_u;
  riscv_pkg::alu_op_e alu_op;
  logic               use_imm;
  logic               is_lui;
  logic               supported;
  riscv_pkg::id_ex_t  id_ex_d;

  // ======================================================================
  // input register
  // ======================================================================

  // idle cycles load a nop so the read ports see x0
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
      inst_q  <= `NOP_INST;
    end else begin
      valid_q <= inst_valid_i;
      inst_q  <= inst_valid_i ? inst_i : `NOP_INST;
    end
  end

  // ======================================================================
  // field decode
  // ======================================================================

  assign opcode = inst_q.r_fmt.opcode;
  assign funct3 = inst_q.r_fmt.funct3;
  assign funct7 = inst_q.r_fmt.funct7;
  assign rs1_o  = inst_q.r_fmt.rs1;
  assign rs2_o  = inst_q.r_fmt.rs2;

  // i-type immediate sits where funct7 and rs2 are
  assign imm_i = {{(`XLEN-12){funct7[6]}}, funct7, inst_q.r_fmt.rs2};
  assign imm_u = {inst_q.u_fmt.imm_hi, 12'h000};

  function automatic riscv_pkg::alu_op_e map_funct(input logic [2:0] f3, input logic f7_5,
                                                   input logic imm_form);
    riscv_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = (f7_5 && !imm_form) ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
      3'b001:  op = riscv_pkg::ALU_SLL;
      3'b010:  op = riscv_pkg::ALU_SLT;
      3'b011:  op = riscv_pkg::ALU_SLTU;
      3'b100:  op = riscv_pkg::ALU_XOR;
      3'b101:  op = f7_5 ? riscv_pkg::ALU_SRA : riscv_pkg::ALU_SRL;
      3'b110:  op = riscv_pkg::ALU_OR;
      default: op = riscv_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    alu_op    = riscv_pkg::ALU_ADD;
    use_imm   = 1'b0;
    is_lui    = 1'b0;
    supported = 1'b0;
    case (opcode)
      riscv_pkg::OP: begin
        supported = 1'b1;
        alu_op    = map_funct(funct3, funct7[5], 1'b0);
      end
      riscv_pkg::OP_IMM: begin
        use_imm = 1'b1;
        alu_op  = map_funct(funct3, funct7[5], 1'b1);
        // shift immediates only allow the standard upper bits
        if (funct3 == 3'b001) begin
          supported = (funct7 == 7'h00);
        end else if (funct3 == 3'b101) begin
          supported = (funct7 == 7'h00) || (funct7 == 7'h20);
        end else begin
          supported = 1'b1;
        end
      end
      riscv_pkg::LUI: begin
        supported = 1'b1;
        is_lui    = 1'b1;
      end
      default: begin
        supported = 1'b0;
      end
    endcase
  end

  always_comb begin
    id_ex_d.valid     = valid_q;
    id_ex_d.rd        = inst_q.r_fmt.rd;
    id_ex_d.rs1       = rs1_o;
    id_ex_d.rs2       = rs2_o;
    id_ex_d.op1_data  = rdata1_i;
    id_ex_d.op2_data  = rdata2_i;
    id_ex_d.imm       = is_lui ? imm_u : imm_i;
    id_ex_d.alu_op    = alu_op;
    id_ex_d.use_imm   = use_imm;
    id_ex_d.is_lui    = is_lui;
    // unsupported or rd x0 goes down as a bubble
    id_ex_d.reg_write = valid_q && supported && (inst_q.r_fmt.rd != '0);
  end

  // ======================================================================
  // id/ex register
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      id_ex_o <= '0;
    end else begin
      id_ex_o <= id_ex_d;
    end
  end

  // writing shift immediates carry the upper field of their alu function
  a_id_ex_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
    id_ex_o.valid |-> !(id_ex_o.is_lui && id_ex_o.use_imm) &&
      (!(id_ex_o.reg_write && id_ex_o.use_imm &&
         (id_ex_o.alu_op inside {riscv_pkg::ALU_SLL, riscv_pkg::ALU_SRL, riscv_pkg::ALU_SRA})) ||
       (id_ex_o.imm[11:5] == ((id_ex_o.alu_op == riscv_pkg::ALU_SRA) ? 7'h20 : 7'h00))));

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module execute_stage (
  input  logic              clk,
  input  logic              rst_n_i,
  input  riscv_pkg::id_ex_t id_ex_i,
  output riscv_pkg::ex_wb_t ex_wb_o
);

  logic              wb_hit;
  logic              fwd1;
  logic              fwd2;
  logic [`XLEN-1:0]  op1_fwd;
  logic [`XLEN-1:0]  op2_fwd;
  logic [`XLEN-1:0]  alu_b;
  logic [`XLEN-1:0]  alu_result;
  riscv_pkg::ex_wb_t ex_wb_d;

  // ======================================================================
  // forwarding
  // ======================================================================

  // previous instruction is still in ex/wb, one cycle ahead
  assign wb_hit = ex_wb_o.valid && ex_wb_o.reg_write;
  assign fwd1   = wb_hit && (ex_wb_o.rd == id_ex_i.rs1);
  assign fwd2   = wb_hit && (ex_wb_o.rd == id_ex_i.rs2);

  assign op1_fwd = fwd1 ? ex_wb_o.result : id_ex_i.op1_data;
  assign op2_fwd = fwd2 ? ex_wb_o.result : id_ex_i.op2_data;

  // immediate forms take b from the decoded immediate
  assign alu_b = id_ex_i.use_imm ? id_ex_i.imm : op2_fwd;

  // ======================================================================
  // alu
  // ======================================================================

  alu u_alu (
    .op_i     (id_ex_i.alu_op),
    .a_i      (op1_fwd),
    .b_i      (alu_b),
    .result_o (alu_result)
  );

  always_comb begin
    ex_wb_d.valid     = id_ex_i.valid;
    ex_wb_d.reg_write = id_ex_i.reg_write;
    ex_wb_d.rd        = id_ex_i.rd;
    // lui bypasses the alu
    ex_wb_d.result    = id_ex_i.is_lui ? id_ex_i.imm : alu_result;
  end

  // ======================================================================
  // ex/wb register
  // ======================================================================

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ex_wb_o <= '0;
    end else begin
      ex_wb_o <= ex_wb_d;
    end
  end

  // decode drops writes to x0 two stages earlier
  a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n_i)
    (ex_wb_o.valid && ex_wb_o.reg_write) |-> (ex_wb_o.rd != '0));

endmodule

// ==== verilog/riscv_core_top.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module riscv_core_top (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   inst_valid_i,
  input  logic [`XLEN-1:0]       inst_i,
  output logic                   wb_valid_o,
  output logic [`REG_ADDR_W-1:0] wb_rd_o,
  output logic [`XLEN-1:0]       wb_data_o
);

  riscv_pkg::id_ex_t      id_ex;
  riscv_pkg::ex_wb_t      ex_wb;
  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`XLEN-1:0]       rdata1;
  logic [`XLEN-1:0]       rdata2;

  decode_stage u_decode (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .rs1_o        (rs1),
    .rs2_o        (rs2),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .id_ex_o      (id_ex)
  );

  execute_stage u_execute (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .id_ex_i (id_ex),
    .ex_wb_o (ex_wb)
  );

  // writeback port and register file share the ex/wb entry
  assign wb_valid_o = ex_wb.valid & ex_wb.reg_write;
  assign wb_rd_o    = ex_wb.rd;
  assign wb_data_o  = ex_wb.result;

  reg_file u_reg_file (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .we_i     (wb_valid_o),
    .waddr_i  (ex_wb.rd),
    .wdata_i  (ex_wb.result),
    .raddr1_i (rs1),
    .raddr2_i (rs2),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

endmodule

// ==== tests/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// rv32i major opcodes the model executes
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;

// architectural registers, x0 never written
logic [31:0] model_regs [32];

// alt selects sub or sra where funct3 allows it
function automatic logic [31:0] compute_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
  logic [4:0] sh;
  sh = b[4:0];
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << sh;
    // signs differ, so a is smaller exactly when negative
    3'd2: return (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
    3'd3: return {31'd0, a < b};
    3'd4: return a ^ b;
    3'd5: return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

task automatic execute_model(input logic [31:0] inst, output logic writes,
                             output logic [4:0] rd, output logic [31:0] data);
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] imm;
  logic        legal;
  f3    = inst[14:12];
  f7    = inst[31:25];
  rd    = inst[11:7];
  imm   = {{20{inst[31]}}, inst[31:20]};
  legal = 1'b1;
  data  = '0;
  case (inst[6:0])
    OPC_OP: begin
      data = compute_alu(f3, f7[5], model_regs[inst[19:15]], model_regs[inst[24:20]]);
    end
    OPC_OP_IMM: begin
      // shift immediates must carry a standard upper field
      if (f3 == 3'd1) begin
        legal = (f7 == 7'h00);
      end else if (f3 == 3'd5) begin
        legal = (f7 == 7'h00) || (f7 == 7'h20);
      end
      data = compute_alu(f3, (f3 == 3'd5) && f7[5], model_regs[inst[19:15]], imm);
    end
    OPC_LUI: begin
      data = {inst[31:12], 12'h000};
    end
    default: begin
      legal = 1'b0;
    end
  endcase
  writes = legal && (rd != 5'd0);
  if (writes) begin
    model_regs[rd] = data;
  end
endtask

`endif

// ==== tests/tb_riscv_core.sv ====
`timescale 1ns/100ps
`include "core_params.svh"

module tb_riscv_core;

  localparam int CLK_PERIOD = 8;
  localparam int NUM_INST   = 2000;

  // one expected writeback and the cycle of its strobe
  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
    logic [31:0]            issue_cycle;
  } wb_entry_t;

  logic                   clk = 1'b0;
  logic                   rst_n_i;
  logic                   inst_valid_i;
  logic [`XLEN-1:0]       inst_i;
  logic                   wb_valid_o;
  logic [`REG_ADDR_W-1:0] wb_rd_o;
  logic [`XLEN-1:0]       wb_data_o;

  integer      seed = 74;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] cycle_cnt = 0;
  wb_entry_t   expected_q [$];
  logic [4:0]  recent_rd [2];

  `include "tb_ref_model.svh"

  riscv_core_top uut (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .inst_valid_i (inst_valid_i),
    .inst_i       (inst_i),
    .wb_valid_o   (wb_valid_o),
    .wb_rd_o      (wb_rd_o),
    .wb_data_o    (wb_data_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // ======================================================================
  // instruction generator
  // ======================================================================

  function automatic logic [31:0] make_instruction();
    int         kind;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [6:0] opc;
    kind = rand_below(100);
    rd   = (rand_below(16) == 0) ? 5'd0 : 5'($random(seed));
    rs1  = 5'($random(seed));
    rs2  = 5'($random(seed));
    f3   = 3'($random(seed));
    f7   = 7'($random(seed));
    // one time in three read a recent destination
    if (rand_below(3) == 0) begin
      if (rand_below(2) == 0) begin
        rs1 = recent_rd[rand_below(2)];
      end else begin
        rs2 = recent_rd[rand_below(2)];
      end
    end
    if (kind < 5) begin
      opc = 7'($random(seed));
      while (opc inside {OPC_OP, OPC_OP_IMM, OPC_LUI}) begin
        opc = 7'($random(seed));
      end
      return {f7, rs2, rs1, f3, rd, opc};
    end else if (kind < 45) begin
      // 0x20 only where it picks sub or sra
      f7 = ((f3 == 3'd0 || f3 == 3'd5) && f7[0]) ? 7'h20 : 7'h00;
      return {f7, rs2, rs1, f3, rd, OPC_OP};
    end else if (kind < 85) begin
      // one shift in eight keeps a random and mostly illegal upper field
      if (rand_below(8) != 0) begin
        if (f3 == 3'd1) begin
          f7 = 7'h00;
        end else if (f3 == 3'd5) begin
          f7 = f7[0] ? 7'h20 : 7'h00;
        end
      end
      return {f7, rs2, rs1, f3, rd, OPC_OP_IMM};
    end
    return {f7, rs2, rs1, f3, rd, OPC_LUI};
  endfunction

  // ======================================================================
  // stimulus
  // ======================================================================

  initial begin : stimulus
    logic        writes;
    logic [4:0]  rd;
    logic [31:0] data;
    logic [31:0] inst;
    int          issued;
    int          drain;
    rst_n_i      = 1'b0;
    inst_valid_i = 1'b0;
    inst_i       = `NOP_INST;
    recent_rd[0] = '0;
    recent_rd[1] = '0;
    issued       = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    while (issued < NUM_INST) begin
      @(posedge clk);
      #1;
      if (rand_below(4) != 0) begin
        inst         = make_instruction();
        inst_valid_i = 1'b1;
        inst_i       = inst;
        execute_model(inst, writes, rd, data);
        if (writes) begin
          expected_q.push_back(wb_entry_t'({rd, data, cycle_cnt}));
        end
        recent_rd[1] = recent_rd[0];
        recent_rd[0] = inst[11:7];
        issued++;
      end else begin
        // word is ignored without the strobe
        inst_valid_i = 1'b0;
        inst_i       = $random(seed);
      end
    end
    @(posedge clk);
    #1;
    inst_valid_i = 1'b0;
    drain = 0;
    while (expected_q.size() != 0 && drain < 10) begin
      @(posedge clk);
      drain++;
    end
    repeat (5) @(posedge clk);
    if (expected_q.size() != 0) begin
      errors++;
      $display("%0d expected writebacks never appeared", expected_q.size());
    end
    $display("summary: %0d writebacks checked, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // ======================================================================
  // writeback checks sampled mid-cycle
  // ======================================================================

  always @(negedge clk) begin : check_wb
    wb_entry_t exp;
    if (!rst_n_i) begin
      if (wb_valid_o !== 1'b0) begin
        errors++;
        $display("wb_valid_o is not low during reset at %0t", $time);
      end
    end else if (wb_valid_o === 1'b1) begin
      checks++;
      if (expected_q.size() == 0) begin
        errors++;
        $display("writeback to x%0d at %0t with no instruction expected", wb_rd_o, $time);
      end else begin
        exp = expected_q.pop_front();
        if (wb_rd_o !== exp.rd || wb_data_o !== exp.data) begin
          errors++;
          $display("Fail %0t: expected x%0d = %h, got x%0d = %h",
                   $time, exp.rd, exp.data, wb_rd_o, wb_data_o);
        end
        if (cycle_cnt != exp.issue_cycle + 3) begin
          errors++;
          $display("Fail %0t: writeback in cycle %0d, expected cycle %0d",
                   $time, cycle_cnt, exp.issue_cycle + 3);
        end
      end
    end else if (wb_valid_o !== 1'b0) begin
      errors++;
      $display("wb_valid_o is unknown at %0t", $time);
    end else if (expected_q.size() != 0 && cycle_cnt >= expected_q[0].issue_cycle + 3) begin
      errors++;
      $display("writeback to x%0d issued in cycle %0d did not appear on time",
               expected_q[0].rd, expected_q[0].issue_cycle);
      void'(expected_q.pop_front());
    end
  end

  // bound on the whole run including reset
  initial begin : watchdog
    #((NUM_INST * 2 + 50) * CLK_PERIOD);
    $display("timeout: the run did not finish in time");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+verilog
+incdir+tests
verilog/riscv_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/riscv_core_top.sv
tests/tb_riscv_core.sv

// ==== Bender.yml ====
package:
  name: riscv_core

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/riscv_pkg.sv
      - verilog/alu.sv
      - verilog/reg_file.sv
      - verilog/decode_stage.sv
      - verilog/execute_stage.sv
      - verilog/riscv_core_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_riscv_core.sv
